// File: src.f
source/cpuPkg.sv
source/busPkg.sv
source/cpuControl.sv
source/instrSequencer.sv
source/execUnit.sv
source/loadStoreUnit.sv
source/busArbiter.sv
source/thumbCore.sv
test/clockGen.sv
test/thumbCore_properties.sv
test/tbThumbCore.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tbThumbCore
FILELIST  := src.f
OBJDIR    := obj_dir

BIN  := $(OBJDIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qx 'test passed'

clean:
	rm -rf $(OBJDIR)

// File: test/tbThumbCore.sv
// Testbench top with memory model, program builder, directed tests, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tbThumbCore
	import cpuPkg::*, busPkg::*;
();

	logic clk, genRstN, tbRstN, rstN;
	logic wbCyc, wbStb, wbWe, wbAck, halted;
	addrT wbAdr;
	dataWordT wbDatW, wbDatR;
	dataWordT mem [256];
	dataWordT prog[$], expWord[$], gotWord[$];
	addrT expAddr[$], gotAddr[$];
	int waitCnt, errors;
	localparam dataWordT NopWord = 16'hBF00;
	localparam dataWordT BkptWord = 16'hBE00;

	assign rstN = genRstN & tbRstN;

	clockGen #(.HalfPeriod(20), .ResetCycles(3)) u_clockGen (.clk(clk), .rstN(genRstN));

	thumbCore #(.ResetVector(16'h0000)) u_thumbCore (
		.clk(clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck), .halted(halted)
	);

	// Memory with 0 to 3 random wait cycles, stores are logged
	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbAck <= 1'b0;
			waitCnt <= $urandom_range(3, 0);
		end else if (wbAck) begin
			wbAck <= 1'b0;
			waitCnt <= $urandom_range(3, 0);
		end else if (wbCyc && wbStb) begin
			if (waitCnt == 0) begin
				wbAck <= 1'b1;
				wbDatR <= mem[wbAdr[7:0]];
				if (wbWe) begin
					mem[wbAdr[7:0]] <= wbDatW;
					gotAddr.push_back(wbAdr);
					gotWord.push_back(wbDatW);
				end
			end else begin
				waitCnt <= waitCnt - 1;
			end
		end
	end

	// Thumb encodings
	function automatic dataWordT movsImm(regIdxT d, logic [7:0] imm);
		return {5'b00100, d, imm};
	endfunction
	function automatic dataWordT addsReg(regIdxT d, regIdxT n, regIdxT m);
		return {7'b0001100, m, n, d};
	endfunction
	function automatic dataWordT subsReg(regIdxT d, regIdxT n, regIdxT m);
		return {7'b0001101, m, n, d};
	endfunction
	function automatic dataWordT addsImm(regIdxT d, regIdxT n, logic [2:0] imm);
		return {7'b0001110, imm, n, d};
	endfunction
	function automatic dataWordT subsImm(regIdxT d, regIdxT n, logic [2:0] imm);
		return {7'b0001111, imm, n, d};
	endfunction
	// ANDS 0, EORS 1, LSLS 2, LSRS 3, CMP A, ORRS C, MVNS F
	function automatic dataWordT dataProc(logic [3:0] op, regIdxT dn, regIdxT m);
		return {6'b010000, op, m, dn};
	endfunction
	function automatic dataWordT strOff(regIdxT t, regIdxT n, logic [4:0] off);
		return {5'b01100, off, n, t};
	endfunction
	function automatic dataWordT ldrOff(regIdxT t, regIdxT n, logic [4:0] off);
		return {5'b01101, off, n, t};
	endfunction
	function automatic dataWordT bCond(logic [3:0] cond, logic [7:0] off);
		return {4'b1101, cond, off};
	endfunction
	function automatic dataWordT bAlways(logic [10:0] off);
		return {5'b11100, off};
	endfunction

	// Flags of a - b, C set when no borrow
	function automatic flagsT cmpFlags(dataWordT a, dataWordT b);
		int sa;
		int sb;
		int diff;
		dataWordT r;
		flagsT f;
		sa = $signed(a);
		sb = $signed(b);
		diff = sa - sb;
		r = a - b;
		f.n = r[15];
		f.z = (a == b);
		f.c = (a >= b);
		f.v = (diff > 32767) || (diff < -32768);
		return f;
	endfunction

	function automatic logic condHolds(logic [3:0] cond, flagsT f);
		case (cond)
			4'h0: return f.z;
			4'h1: return !f.z;
			4'h2: return f.c;
			4'h3: return !f.c;
			4'h4: return f.n;
			4'h5: return !f.n;
			4'hA: return f.n == f.v;
			4'hB: return f.n != f.v;
			4'hC: return !f.z && (f.n == f.v);
			4'hD: return f.z || (f.n != f.v);
			default: return 1'b0;
		endcase
	endfunction

	task automatic checkAddr(addrT got, addrT exp, string what);
		if (got !== exp) begin
			$display("ERROR at %0t: %s store address %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic checkWord(dataWordT got, dataWordT exp, string what);
		if (got !== exp) begin
			$display("ERROR at %0t: %s store data %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic expectStore(addrT a, dataWordT w);
		expAddr.push_back(a);
		expWord.push_back(w);
	endtask

	// Fill unused words with BKPT tagged by address
	task automatic runProgram();
		for (int i = 0; i < 256; i++) begin
			mem[i] <= (i < prog.size()) ? prog[i] : {8'hBE, i[7:0]};
		end
		gotAddr.delete();
		gotWord.delete();
		@(posedge clk) tbRstN <= 1'b0;
		repeat (3) @(posedge clk);
		tbRstN <= 1'b1;
		@(posedge clk);
		while (!halted) @(posedge clk);
	endtask

	task automatic checkStores(string what);
		int n;
		if (gotAddr.size() != expAddr.size()) begin
			$display("%s: expected %0d stores but saw %0d", what, expAddr.size(), gotAddr.size());
			errors++;
		end
		n = (gotAddr.size() < expAddr.size()) ? gotAddr.size() : expAddr.size();
		for (int i = 0; i < n; i++) begin
			checkAddr(gotAddr[i], expAddr[i], what);
			checkWord(gotWord[i], expWord[i], what);
		end
		expAddr.delete();
		expWord.delete();
		prog.delete();
	endtask

	task automatic arithTest();
		prog = '{movsImm(0, 100), movsImm(1, 200), movsImm(7, 8'h80),
			addsReg(2, 0, 1), strOff(2, 7, 0), subsReg(3, 0, 1), strOff(3, 7, 1),
			addsImm(4, 0, 7), strOff(4, 7, 2), subsImm(5, 0, 3), strOff(5, 7, 3), BkptWord};
		expectStore(16'h80, 16'd300);
		expectStore(16'h81, 16'd100 - 16'd200);
		expectStore(16'h82, 16'd107);
		expectStore(16'h83, 16'd97);
		runProgram();
		checkStores("arithmetic");
	endtask

	task automatic logicTest();
		prog = '{movsImm(1, 8'h3C), movsImm(7, 8'h80), movsImm(6, 4),
			movsImm(2, 8'hF0), dataProc(4'h0, 2, 1), strOff(2, 7, 0),
			movsImm(3, 8'hF0), dataProc(4'h1, 3, 1), strOff(3, 7, 1),
			movsImm(4, 8'hF0), dataProc(4'hC, 4, 1), strOff(4, 7, 2),
			dataProc(4'hF, 5, 1), strOff(5, 7, 3),
			movsImm(2, 8'hF0), dataProc(4'h2, 2, 6), strOff(2, 7, 4),
			movsImm(3, 8'hF0), dataProc(4'h3, 3, 6), strOff(3, 7, 5),
			movsImm(6, 16), movsImm(4, 8'hF0), dataProc(4'h2, 4, 6), strOff(4, 7, 6),
			BkptWord};
		expectStore(16'h80, 16'h00F0 & 16'h003C);
		expectStore(16'h81, 16'h00F0 ^ 16'h003C);
		expectStore(16'h82, 16'h00F0 | 16'h003C);
		expectStore(16'h83, ~16'h003C);
		expectStore(16'h84, 16'h00F0 << 4);
		expectStore(16'h85, 16'h00F0 >> 4);
		expectStore(16'h86, 16'h0000);
		runProgram();
		checkStores("logic and shifts");
	endtask

	task automatic loadStoreTest();
		prog = '{movsImm(7, 8'h90), movsImm(0, 8'h5A), strOff(0, 7, 5), ldrOff(1, 7, 5),
			movsImm(6, 8'hA0), strOff(1, 6, 31), addsImm(1, 1, 1), strOff(1, 6, 0),
			BkptWord};
		expectStore(16'h90 + 16'd5, 16'h005A);
		expectStore(16'hA0 + 16'd31, 16'h005A);
		expectStore(16'hA0, 16'h005B);
		runProgram();
		checkStores("load/store");
	endtask

	// Not-taken path stores 0x11, taken path stores 0x22
	task automatic branchTest();
		logic [3:0] conds [10] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hA, 4'hB, 4'hC, 4'hD};
		logic [7:0] lhs [3] = '{8'd5, 8'd3, 8'd9};
		logic [7:0] rhs [3] = '{8'd5, 8'd9, 8'd3};
		flagsT f;
		int k;
		k = 0;
		prog = '{movsImm(5, 8'h11), movsImm(6, 8'h22), movsImm(7, 8'hE0)};
		for (int p = 0; p < 3; p++) begin
			prog.push_back(movsImm(0, lhs[p]));
			prog.push_back(movsImm(1, rhs[p]));
			prog.push_back(dataProc(4'hA, 0, 1));
			f = cmpFlags({8'd0, lhs[p]}, {8'd0, rhs[p]});
			for (int c = 0; c < 10; c++) begin
				prog.push_back(bCond(conds[c], 8'd2));
				prog.push_back(strOff(5, 7, k[4:0]));
				prog.push_back(bAlways(11'd1));
				prog.push_back(strOff(6, 7, k[4:0]));
				expectStore(16'hE0 + k[15:0], condHolds(conds[c], f) ? 16'h22 : 16'h11);
				k++;
			end
		end
		prog.push_back(bAlways(11'd1));
		prog.push_back(strOff(5, 7, 30));
		prog.push_back(strOff(6, 7, 31));
		prog.push_back(BkptWord);
		expectStore(16'hFF, 16'h22);
		runProgram();
		checkStores("conditional branches");
	endtask

	task automatic randomTest();
		logic [7:0] a, b;
		flagsT f;
		prog = '{movsImm(7, 8'hC0), movsImm(6, 8'hE0)};
		for (int i = 0; i < 20; i++) begin
			a = $urandom_range(255, 0);
			b = $urandom_range(255, 0);
			prog.push_back(movsImm(0, a));
			prog.push_back(movsImm(1, b));
			prog.push_back(addsReg(2, 0, 1));
			prog.push_back(subsReg(3, 0, 1));
			prog.push_back(strOff(2, 7, i[4:0]));
			prog.push_back(dataProc(4'hA, 0, 1));
			prog.push_back(bCond(4'hB, 8'd1));
			prog.push_back(strOff(3, 6, i[4:0]));
			expectStore(16'hC0 + i[15:0], {8'd0, a} + {8'd0, b});
			f = cmpFlags({8'd0, a}, {8'd0, b});
			if (f.n == f.v) begin
				expectStore(16'hE0 + i[15:0], {8'd0, a} - {8'd0, b});
			end
		end
		prog.push_back(BkptWord);
		runProgram();
		checkStores("random operands");
	endtask

	task automatic haltTest();
		prog = '{movsImm(0, 8'h42), movsImm(7, 8'h80), NopWord, strOff(0, 7, 0), NopWord,
			BkptWord};
		expectStore(16'h80, 16'h0042);
		runProgram();
		checkStores("halt");
		repeat (20) begin
			@(posedge clk);
			if (wbCyc || !halted) begin
				$display("core left the halted state or used the bus after BKPT at %0t", $time);
				errors++;
			end
		end
	endtask

	// Six tests, up to 200 instructions each at about 10 cycles
	initial begin
		#(6 * 200 * 10 * 40);
		$display("watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

	initial begin
		void'($urandom(15));
		wbAck = 1'b0;
		wbDatR = '0;
		tbRstN = 1'b1;
		errors = 0;
		@(posedge clk);
		while (!genRstN) @(posedge clk);
		arithTest();
		logicTest();
		loadStoreTest();
		branchTest();
		randomTest();
		haltTest();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/thumbCore_properties.sv
// Bus protocol and halt assertions bound to the core top level
`timescale 1ns/1ps
`default_nettype none

module thumbCoreProperties
	import cpuPkg::*, busPkg::*;
(
	input logic     clk,
	input logic     rstN,
	input logic     wbCyc,
	input logic     wbStb,
	input logic     wbWe,
	input addrT     wbAdr,
	input dataWordT wbDatW,
	input logic     wbAck,
	input logic     halted
);

	stbNeedsCyc: assert property (@(posedge clk) disable iff (!rstN) wbStb |-> wbCyc)
		else $error("wbStb high while wbCyc is low");

	// A waiting cycle keeps its request unchanged
	reqStable: assert property (@(posedge clk) disable iff (!rstN)
		(wbCyc && !wbAck) |=> (wbCyc && $stable(wbAdr) && $stable(wbDatW) && $stable(wbWe)))
		else $error("bus request changed before ack");

	haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
		else $error("halted fell without reset");

endmodule

bind thumbCore thumbCoreProperties u_thumbCoreProperties (.*);

`default_nettype wire

// File: test/clockGen.sv
// Testbench clock source and power-on reset generator
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
	parameter int HalfPeriod = 20,
	parameter int ResetCycles = 3
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk  = 1'b0;
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		rstN <= 1'b1;
	end

	always #(HalfPeriod) clk = ~clk;

endmodule

`default_nettype wire

// File: source/thumbCore.sv
// Thumb core top level joining decoder, sequencer, datapath, load/store and arbiter
`timescale 1ns/1ps
`default_nettype none

module thumbCore
	import cpuPkg::*, busPkg::*;
#(
	parameter addrT ResetVector = '0
) (
	input  logic     clk,
	input  logic     rstN,
	output logic     wbCyc,
	output logic     wbStb,
	output logic     wbWe,
	output addrT     wbAdr,
	output dataWordT wbDatW,
	input  dataWordT wbDatR,
	input  logic     wbAck,
	output logic     halted
);

	dataWordT  instr;
	flagsT     flags;
	logic      regWrite, memWrite, memRead, setNZ, setCV, halt;
	aluOpT     aluOp;
	opBSelT    opBSel;
	wrDataSelT wrDataSel;
	brSelT     brSel;
	regIdxT    reg1Loc, reg2Loc, reg3Loc;
	logic      execEn, loadWrEn, memDone;
	addrT      memAddr;
	dataWordT  storeData, loadData;
	logic      fetchCyc, fetchStb, fetchAck;
	addrT      fetchAdr;
	dataWordT  fetchDatR;
	logic      dataCyc, dataStb, dataWe, dataAck;
	addrT      dataAdr;
	dataWordT  dataDatW, dataDatR;

	cpuControl u_cpuControl (
		.instr(instr), .flags(flags), .regWrite(regWrite), .memWrite(memWrite),
		.memRead(memRead), .setNZ(setNZ), .setCV(setCV), .halt(halt), .aluOp(aluOp),
		.opBSel(opBSel), .wrDataSel(wrDataSel), .brSel(brSel),
		.reg1Loc(reg1Loc), .reg2Loc(reg2Loc), .reg3Loc(reg3Loc)
	);

	instrSequencer #(.ResetVector(ResetVector)) u_instrSequencer (
		.clk(clk), .rstN(rstN), .fetchAck(fetchAck), .fetchDatR(fetchDatR),
		.brSel(brSel), .halt(halt), .memRead(memRead), .memWrite(memWrite),
		.memDone(memDone), .fetchCyc(fetchCyc), .fetchStb(fetchStb),
		.fetchAdr(fetchAdr), .instr(instr), .execEn(execEn), .loadWrEn(loadWrEn),
		.halted(halted)
	);

	execUnit u_execUnit (
		.clk(clk), .rstN(rstN), .execEn(execEn), .loadWrEn(loadWrEn), .instr(instr),
		.regWrite(regWrite), .setNZ(setNZ), .setCV(setCV), .aluOp(aluOp),
		.opBSel(opBSel), .wrDataSel(wrDataSel), .reg1Loc(reg1Loc), .reg2Loc(reg2Loc),
		.reg3Loc(reg3Loc), .loadData(loadData), .flags(flags), .memAddr(memAddr),
		.storeData(storeData)
	);

	loadStoreUnit u_loadStoreUnit (
		.clk(clk), .rstN(rstN), .memRead(memRead), .memWrite(memWrite),
		.execEn(execEn), .memAddr(memAddr), .storeData(storeData), .dataAck(dataAck),
		.dataDatR(dataDatR), .dataCyc(dataCyc), .dataStb(dataStb), .dataWe(dataWe),
		.dataAdr(dataAdr), .dataDatW(dataDatW), .loadData(loadData), .memDone(memDone)
	);

	// Fetch master only reads
	busArbiter u_busArbiter (
		.clk(clk), .rstN(rstN),
		.fetchCyc(fetchCyc), .fetchStb(fetchStb), .fetchWe(1'b0), .fetchAdr(fetchAdr),
		.fetchDatW('0), .fetchAck(fetchAck), .fetchDatR(fetchDatR),
		.dataCyc(dataCyc), .dataStb(dataStb), .dataWe(dataWe), .dataAdr(dataAdr),
		.dataDatW(dataDatW), .dataAck(dataAck), .dataDatR(dataDatR),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
		.wbDatR(wbDatR), .wbAck(wbAck)
	);

endmodule

`default_nettype wire

// File: source/busArbiter.sv
// Two-master Wishbone classic arbiter with held grant
`timescale 1ns/1ps
`default_nettype none

module busArbiter
	import cpuPkg::*, busPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     fetchCyc,
	input  logic     fetchStb,
	input  logic     fetchWe,
	input  addrT     fetchAdr,
	input  dataWordT fetchDatW,
	output logic     fetchAck,
	output dataWordT fetchDatR,
	input  logic     dataCyc,
	input  logic     dataStb,
	input  logic     dataWe,
	input  addrT     dataAdr,
	input  dataWordT dataDatW,
	output logic     dataAck,
	output dataWordT dataDatR,
	output logic     wbCyc,
	output logic     wbStb,
	output logic     wbWe,
	output addrT     wbAdr,
	output dataWordT wbDatW,
	input  dataWordT wbDatR,
	input  logic     wbAck
);

	masterIdT grant;
	masterIdT sel;
	logic     busy;
	logic     grantCyc;

	assign grantCyc = (grant == DATA) ? dataCyc : fetchCyc;

	// Held grant while its cyc stays high, else DATA has priority
	always_comb begin
		if (busy && grantCyc) begin
			sel = grant;
		end else begin
			sel = dataCyc ? DATA : FETCH;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy  <= 1'b0;
			grant <= FETCH;
		end else begin
			busy  <= wbCyc;
			grant <= sel;
		end
	end

	assign wbCyc  = (sel == DATA) ? dataCyc : fetchCyc;
	assign wbStb  = (sel == DATA) ? dataStb : fetchStb;
	assign wbWe   = (sel == DATA) ? dataWe : fetchWe;
	assign wbAdr  = (sel == DATA) ? dataAdr : fetchAdr;
	assign wbDatW = (sel == DATA) ? dataDatW : fetchDatW;

	assign fetchAck  = wbAck && wbCyc && (sel == FETCH);
	assign dataAck   = wbAck && wbCyc && (sel == DATA);
	assign fetchDatR = (sel == FETCH) ? wbDatR : '0;
	assign dataDatR  = (sel == DATA) ? wbDatR : '0;

endmodule

`default_nettype wire

// File: source/loadStoreUnit.sv
// Wishbone data master for LDR and STR
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit
	import cpuPkg::*, busPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     memRead,
	input  logic     memWrite,
	input  logic     execEn,
	input  addrT     memAddr,
	input  dataWordT storeData,
	input  logic     dataAck,
	input  dataWordT dataDatR,
	output logic     dataCyc,
	output logic     dataStb,
	output logic     dataWe,
	output addrT     dataAdr,
	output dataWordT dataDatW,
	output dataWordT loadData,
	output logic     memDone
);

	logic startReq;

	// Memory access begins on the edge that ends EXEC
	assign startReq = execEn && (memRead || memWrite);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			dataCyc <= 1'b0;
			dataWe  <= 1'b0;
		end else if (dataCyc) begin
			if (dataAck) begin
				dataCyc <= 1'b0;
				dataWe  <= 1'b0;
			end
		end else if (startReq) begin
			dataCyc <= 1'b1;
			dataWe  <= memWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (startReq && !dataCyc) begin
			dataAdr  <= memAddr;
			dataDatW <= storeData;
		end
	end

	assign dataStb  = dataCyc;
	assign memDone  = dataCyc && dataAck;
	// Read data valid in the ack cycle only
	assign loadData = dataDatR;

endmodule

`default_nettype wire

// File: source/execUnit.sv
// Register file, ALU with shifter, and NZCV flag register
`timescale 1ns/1ps
`default_nettype none

module execUnit
	import cpuPkg::*, busPkg::*;
(
	input  logic      clk,
	input  logic      rstN,
	input  logic      execEn,
	input  logic      loadWrEn,
	input  dataWordT  instr,
	input  logic      regWrite,
	input  logic      setNZ,
	input  logic      setCV,
	input  aluOpT     aluOp,
	input  opBSelT    opBSel,
	input  wrDataSelT wrDataSel,
	input  regIdxT    reg1Loc,
	input  regIdxT    reg2Loc,
	input  regIdxT    reg3Loc,
	input  dataWordT  loadData,
	output flagsT     flags,
	output addrT      memAddr,
	output dataWordT  storeData
);

	dataWordT    regs [8];
	dataWordT    opA;
	dataWordT    opB;
	dataWordT    result;
	dataWordT    wrData;
	logic [16:0] sum;
	logic        carry;
	logic        overflow;
	logic        wrEn;

	assign opA = regs[reg1Loc];

	always_comb begin
		case (opBSel)
			IMM3:    opB = {13'd0, instr[8:6]};
			IMM8:    opB = {8'd0, instr[7:0]};
			OFF5:    opB = {11'd0, instr[10:6]};
			default: opB = regs[reg2Loc];
		endcase
	end

	// C is the no-borrow bit on subtract
	always_comb begin
		sum      = {1'b0, opA} + {1'b0, opB};
		result   = sum[15:0];
		carry    = sum[16];
		overflow = (opA[15] == opB[15]) && (sum[15] != opA[15]);
		case (aluOp)
			SUB: begin
				sum      = {1'b0, opA} + {1'b0, ~opB} + 17'd1;
				result   = sum[15:0];
				carry    = sum[16];
				overflow = (opA[15] != opB[15]) && (sum[15] != opA[15]);
			end
			AND:   result = opA & opB;
			EOR:   result = opA ^ opB;
			ORR:   result = opA | opB;
			MVN:   result = ~opB;
			PASSB: result = opB;
			// Shift amount from the low byte, 16 and up clears
			LSL:   result = (opB[7:4] != 4'd0) ? '0 : opA << opB[3:0];
			LSR:   result = (opB[7:4] != 4'd0) ? '0 : opA >> opB[3:0];
			default: ;
		endcase
	end

	assign wrEn   = loadWrEn || (execEn && regWrite && wrDataSel == ALU);
	assign wrData = (wrDataSel == MEM) ? loadData : result;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
			flags <= '0;
		end else begin
			if (wrEn) begin
				regs[reg3Loc] <= wrData;
			end
			if (execEn && setNZ) begin
				flags.n <= result[15];
				flags.z <= (result == '0);
			end
			if (execEn && setCV) begin
				flags.c <= carry;
				flags.v <= overflow;
			end
		end
	end

	assign memAddr   = result;
	assign storeData = regs[reg2Loc];

endmodule

`default_nettype wire

// File: source/instrSequencer.sv
// Program counter, instruction register, fetch master and core FSM
`timescale 1ns/1ps
`default_nettype none

module instrSequencer
	import cpuPkg::*, busPkg::*;
#(
	parameter addrT ResetVector = '0
) (
	input  logic     clk,
	input  logic     rstN,
	input  logic     fetchAck,
	input  dataWordT fetchDatR,
	input  brSelT    brSel,
	input  logic     halt,
	input  logic     memRead,
	input  logic     memWrite,
	input  logic     memDone,
	output logic     fetchCyc,
	output logic     fetchStb,
	output addrT     fetchAdr,
	output dataWordT instr,
	output logic     execEn,
	output logic     loadWrEn,
	output logic     halted
);

	typedef enum logic [1:0] {FETCH, EXEC, MEM, HALTED} stateT;

	stateT    state;
	addrT     pc;
	addrT     nextPc;
	dataWordT ir;
	logic     isMem;

	assign isMem = memRead | memWrite;

	// Branch offsets are relative to the following instruction
	always_comb begin
		case (brSel)
			COND:    nextPc = pc + 16'd1 + {{8{ir[7]}}, ir[7:0]};
			UNC:     nextPc = pc + 16'd1 + {{5{ir[10]}}, ir[10:0]};
			default: nextPc = pc + 16'd1;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state    <= FETCH;
			pc       <= ResetVector;
			fetchCyc <= 1'b0;
			halted   <= 1'b0;
		end else begin
			case (state)
				FETCH: begin
					// First fetch after reset is raised here
					if (!fetchCyc) begin
						fetchCyc <= 1'b1;
					end else if (fetchAck) begin
						fetchCyc <= 1'b0;
						state    <= EXEC;
					end
				end
				EXEC: begin
					if (halt) begin
						state  <= HALTED;
						halted <= 1'b1;
					end else begin
						pc <= nextPc;
						if (isMem) begin
							state <= MEM;
						end else begin
							state    <= FETCH;
							fetchCyc <= 1'b1;
						end
					end
				end
				MEM: begin
					if (memDone) begin
						state    <= FETCH;
						fetchCyc <= 1'b1;
					end
				end
				HALTED: state <= HALTED;
				default: state <= FETCH;
			endcase
		end
	end

	// Instruction register loads in the fetch ack cycle
	always_ff @(posedge clk) begin
		if (state == FETCH && fetchCyc && fetchAck) begin
			ir <= fetchDatR;
		end
	end

	assign fetchStb = fetchCyc;
	assign fetchAdr = pc;
	assign instr    = ir;
	assign execEn   = (state == EXEC);
	assign loadWrEn = (state == MEM) && memRead && memDone;

endmodule

`default_nettype wire

// File: source/cpuControl.sv
// Instruction decoder driving datapath controls and resolving branch conditions
`timescale 1ns/1ps
`default_nettype none

module cpuControl
	import cpuPkg::*;
(
	input  dataWordT  instr,
	input  flagsT     flags,
	output logic      regWrite,
	output logic      memWrite,
	output logic      memRead,
	output logic      setNZ,
	output logic      setCV,
	output logic      halt,
	output aluOpT     aluOp,
	output opBSelT    opBSel,
	output wrDataSelT wrDataSel,
	output brSelT     brSel,
	output regIdxT    reg1Loc,
	output regIdxT    reg2Loc,
	output regIdxT    reg3Loc
);

	instrClassT cls;
	logic       condPass;

	// Classify by the fixed opcode bits
	always_comb begin
		casez (instr)
			16'b0010_0???_????_????: cls = MOVI;
			16'b0001_100?_????_????: cls = ADDR;
			16'b0001_101?_????_????: cls = SUBR;
			16'b0001_110?_????_????: cls = ADDI;
			16'b0001_111?_????_????: cls = SUBI;
			16'b0100_0000_00??_????: cls = ANDR;
			16'b0100_0000_01??_????: cls = EORR;
			16'b0100_0000_10??_????: cls = LSLR;
			16'b0100_0000_11??_????: cls = LSRR;
			16'b0100_0010_10??_????: cls = CMPR;
			16'b0100_0011_00??_????: cls = ORRR;
			16'b0100_0011_11??_????: cls = MVNR;
			16'b0110_0???_????_????: cls = STRI;
			16'b0110_1???_????_????: cls = LDRI;
			16'b1101_????_????_????: cls = BCOND;
			16'b1110_0???_????_????: cls = BUNC;
			16'b1011_1111_0000_0000: cls = NOP;
			16'b1011_1110_????_????: cls = HALT;
			default:                 cls = ILLEGAL;
		endcase
	end

	// Condition field of B<cond> against NZCV
	always_comb begin
		case (instr[11:8])
			4'h0:    condPass = flags.z;
			4'h1:    condPass = !flags.z;
			4'h2:    condPass = flags.c;
			4'h3:    condPass = !flags.c;
			4'h4:    condPass = flags.n;
			4'h5:    condPass = !flags.n;
			4'hA:    condPass = (flags.n == flags.v);
			4'hB:    condPass = (flags.n != flags.v);
			4'hC:    condPass = !flags.z && (flags.n == flags.v);
			4'hD:    condPass = flags.z || (flags.n != flags.v);
			default: condPass = 1'b0;
		endcase
	end

	always_comb begin
		regWrite  = 1'b0;
		memWrite  = 1'b0;
		memRead   = 1'b0;
		setNZ     = 1'b0;
		setCV     = 1'b0;
		halt      = 1'b0;
		aluOp     = ADD;
		opBSel    = REG;
		wrDataSel = ALU;
		brSel     = SEQ;
		// Two-register data-processing layout
		reg1Loc   = instr[2:0];
		reg2Loc   = instr[5:3];
		reg3Loc   = instr[2:0];
		case (cls)
			MOVI: begin
				aluOp    = PASSB;
				opBSel   = IMM8;
				reg3Loc  = instr[10:8];
				regWrite = 1'b1;
				setNZ    = 1'b1;
			end
			ADDI, ADDR, SUBI, SUBR: begin
				reg1Loc  = instr[5:3];
				reg2Loc  = instr[8:6];
				regWrite = 1'b1;
				setNZ    = 1'b1;
				setCV    = 1'b1;
				if (cls == SUBI || cls == SUBR) begin
					aluOp = SUB;
				end
				if (cls == ADDI || cls == SUBI) begin
					opBSel = IMM3;
				end
			end
			CMPR: begin
				aluOp = SUB;
				setNZ = 1'b1;
				setCV = 1'b1;
			end
			ANDR, EORR, ORRR, MVNR, LSLR, LSRR: begin
				regWrite = 1'b1;
				setNZ    = 1'b1;
				case (cls)
					ANDR:    aluOp = AND;
					EORR:    aluOp = EOR;
					ORRR:    aluOp = ORR;
					MVNR:    aluOp = MVN;
					LSLR:    aluOp = LSL;
					default: aluOp = LSR;
				endcase
			end
			// Base plus word offset, data register in bits 2:0
			STRI: begin
				opBSel   = OFF5;
				reg1Loc  = instr[5:3];
				reg2Loc  = instr[2:0];
				memWrite = 1'b1;
			end
			LDRI: begin
				opBSel    = OFF5;
				reg1Loc   = instr[5:3];
				memRead   = 1'b1;
				regWrite  = 1'b1;
				wrDataSel = MEM;
			end
			BCOND: begin
				if (condPass) begin
					brSel = COND;
				end
			end
			BUNC: brSel = UNC;
			HALT: halt = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: source/busPkg.sv
// Bus types: word address and bus-master identifier
`default_nettype none

package busPkg;

	// Word address, one 16-bit word per location
	typedef logic [15:0] addrT;

	// Masters sharing the external bus
	typedef enum logic {
		FETCH,
		DATA
	} masterIdT;

endpackage

`default_nettype wire

// File: source/cpuPkg.sv
// Instruction-set types: instruction classes, ALU operations, operand selects, word types
`default_nettype none

package cpuPkg;

	// One register or memory word
	typedef logic [15:0] dataWordT;

	// Register number, r0 to r7
	typedef logic [2:0] regIdxT;

	// Decoded instruction kinds
	typedef enum logic [4:0] {
		MOVI, ADDI, ADDR, SUBI, SUBR,
		CMPR, ANDR, EORR, ORRR, MVNR,
		LSLR, LSRR, STRI, LDRI,
		BCOND, BUNC, NOP, HALT, ILLEGAL
	} instrClassT;

	// ALU and shifter operations
	typedef enum logic [3:0] {
		ADD, SUB, AND, EOR, ORR,
		MVN, PASSB, LSL, LSR
	} aluOpT;

	// Source of ALU operand B
	typedef enum logic [1:0] {
		REG,   // second register
		IMM3,  // bits 8:6
		IMM8,  // bits 7:0
		OFF5   // bits 10:6, word offset
	} opBSelT;

	// Register write source
	typedef enum logic {
		ALU,
		MEM
	} wrDataSelT;

	// Next PC choice
	typedef enum logic [1:0] {
		SEQ,   // PC+1
		COND,  // PC+1 plus 8-bit offset
		UNC    // PC+1 plus 11-bit offset
	} brSelT;

	// Condition flags, N in the top bit
	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flagsT;

endpackage

`default_nettype wire
